// File: verilog.f
+incdir+verilog
+incdir+verification
verilog/rename_pkg.sv
verilog/rob_tag_allocator.sv
verilog/rename_lookup.sv
verilog/rename_map.sv
verilog/rename_stage.sv
verification/rename_tb.sv

// File: Makefile
# Verilator build and run of the rename stage testbench
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= All checks passed

SOURCES := $(wildcard verilog/*.sv verilog/*.svh verification/*.sv verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/rename_tests.svh
// ======================================================================
// Reference model and stimulus helpers
// ======================================================================

task automatic reset_model();
    for (int i = 0; i < `RN_ARCH_REGS; i++) begin
        ref_map[i] = i;
    end
    ref_ptr = 0;
    ref_free = `RN_ROB_DEPTH;
    inflight.delete();
endtask

function automatic rename_pkg::rename_req_t make_req(input logic valid, input logic rd_we,
                                                     input int rs1, input int rs2, input int rd);
    rename_pkg::rename_req_t r;
    r.valid = valid;
    r.rd_we = rd_we;
    r.rs1 = rename_pkg::arch_addr_t'(rs1);
    r.rs2 = rename_pkg::arch_addr_t'(rs2);
    r.rd = rename_pkg::arch_addr_t'(rd);
    return r;
endfunction

// Expected outputs from the model before it steps over the edge
task automatic check_and_step();
    int needed;
    int granted;
    int exp_tag [`RN_WIDTH];
    logic [`RN_WIDTH-1:0] exp_grant;
    logic [`RN_WIDTH-1:0] wen;
    int exp_rs1;
    int exp_rs2;
    int exp_old;
    int exp_ready;
    rename_pkg::commit_t entry;
    needed = 0;
    granted = 0;
    // Thermometer of up to three free tags
    exp_ready = (ref_free >= 3) ? 7 : (ref_free == 2) ? 3 : ref_free;
    check_value("rename_ready_o", 32'(rename_ready), exp_ready);
    // Grants in slot order with consecutive tags from the pointer
    for (int k = 0; k < `RN_WIDTH; k++) begin
        if (cur_req[k].valid) begin
            needed++;
        end
        exp_grant[k] = cur_req[k].valid && (needed <= ref_free);
        exp_tag[k] = (ref_ptr + granted) % `RN_ROB_DEPTH;
        if (exp_grant[k]) begin
            granted++;
        end
        wen[k] = exp_grant[k] && cur_req[k].rd_we && (cur_req[k].rd != '0);
    end
    for (int k = 0; k < `RN_WIDTH; k++) begin
        exp_rs1 = ref_map[cur_req[k].rs1];
        exp_rs2 = ref_map[cur_req[k].rs2];
        exp_old = ref_map[cur_req[k].rd];
        // Youngest older writer in the group wins
        for (int j = 0; j < k; j++) begin
            if (wen[j] && cur_req[j].rd == cur_req[k].rs1) begin
                exp_rs1 = 32 + exp_tag[j];
            end
            if (wen[j] && cur_req[j].rd == cur_req[k].rs2) begin
                exp_rs2 = 32 + exp_tag[j];
            end
            if (wen[j] && cur_req[j].rd == cur_req[k].rd) begin
                exp_old = 32 + exp_tag[j];
            end
        end
        check_value($sformatf("rsp[%0d].valid", k), 32'(rsp[k].valid), 32'(exp_grant[k]));
        check_value($sformatf("rsp[%0d].rs1_phys", k), 32'(rsp[k].rs1_phys), exp_rs1);
        check_value($sformatf("rsp[%0d].rs2_phys", k), 32'(rsp[k].rs2_phys), exp_rs2);
        check_value($sformatf("rsp[%0d].rd_phys", k), 32'(rsp[k].rd_phys),
                    exp_grant[k] ? 32 + exp_tag[k] : 0);
        check_value($sformatf("rsp[%0d].old_rd_phys", k), 32'(rsp[k].old_rd_phys),
                    exp_grant[k] ? exp_old : 0);
    end
    // Commits go first and release only while the entry still names the tag
    for (int k = 0; k < `RN_WIDTH; k++) begin
        if (cur_commit[k].valid) begin
            ref_free++;
            if (cur_commit[k].arch != '0 &&
                ref_map[cur_commit[k].arch] == 32 + int'(cur_commit[k].rob_tag)) begin
                ref_map[cur_commit[k].arch] = int'(cur_commit[k].arch);
            end
        end
    end
    // Renames in slot order and every granted tag joins the in-flight queue
    for (int k = 0; k < `RN_WIDTH; k++) begin
        if (exp_grant[k]) begin
            entry.valid = 1'b1;
            entry.arch = wen[k] ? cur_req[k].rd : '0;
            entry.rob_tag = rename_pkg::rob_tag_t'(exp_tag[k]);
            inflight.push_back(entry);
            if (wen[k]) begin
                ref_map[cur_req[k].rd] = 32 + exp_tag[k];
            end
        end
    end
    if (cur_flush) begin
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            ref_map[i] = i;
        end
    end
    ref_ptr = (ref_ptr + granted) % `RN_ROB_DEPTH;
    ref_free = ref_free - granted;
endtask

// Drive on the falling edge and check well before the rising edge
task automatic run_cycle();
    @(negedge clk);
    req = cur_req;
    commit = cur_commit;
    flush_i = cur_flush;
    #20;
    check_and_step();
    cur_req = '0;
    cur_commit = '0;
    cur_flush = 1'b0;
endtask

// Oldest tags retire in order
task automatic retire_oldest(input int n);
    for (int k = 0; k < n && k < `RN_WIDTH; k++) begin
        if (inflight.size() > 0) begin
            cur_commit[k] = inflight.pop_front();
        end
    end
    run_cycle();
endtask

task automatic retire_all();
    while (inflight.size() > 0) begin
        retire_oldest(`RN_WIDTH);
    end
endtask

// Reads all 32 entries through idle slots against the model
task automatic check_table();
    for (int c = 0; c < 6; c++) begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            cur_req[k] = make_req(1'b0, 1'b0, (6 * c + 2 * k) % 32, (6 * c + 2 * k + 1) % 32, 0);
        end
        run_cycle();
    end
endtask

task automatic expect_mapping(input int r, input int expected);
    cur_req[0] = make_req(1'b0, 1'b0, r, r, 0);
    run_cycle();
    check_value($sformatf("rsp[0].rs1_phys for x%0d", r), 32'(rsp[0].rs1_phys), expected);
endtask

task automatic random_group();
    int rnd;
    for (int k = 0; k < `RN_WIDTH; k++) begin
        rnd = $random(seed);
        cur_req[k] = make_req(1'b1, 1'b1, rnd & 31, (rnd >> 5) & 31, (rnd >> 10) & 31);
    end
    run_cycle();
endtask

// ======================================================================
// Directed tests
// ======================================================================

task automatic after_reset_state();
    run_cycle();
    check_value("rename_ready_o", 32'(rename_ready), 7);
    check_table();
endtask

task automatic tag_sequence();
    for (int k = 0; k < `RN_WIDTH; k++) begin
        cur_req[k] = make_req(1'b1, 1'b1, 0, 0, k + 1);
    end
    run_cycle();
    for (int k = 0; k < `RN_WIDTH; k++) begin
        check_value($sformatf("rsp[%0d].rd_phys", k), 32'(rsp[k].rd_phys), 32 + k);
    end
    // Second group continues after the first
    for (int k = 0; k < `RN_WIDTH; k++) begin
        cur_req[k] = make_req(1'b1, 1'b1, 0, 0, k + 4);
    end
    run_cycle();
    for (int k = 0; k < `RN_WIDTH; k++) begin
        check_value($sformatf("rsp[%0d].rd_phys", k), 32'(rsp[k].rd_phys), 35 + k);
    end
endtask

task automatic group_bypass();
    int base;
    base = 32 + ref_ptr;
    // Slots 0 and 1 both rename x5 and slot 2 sees the younger tag
    cur_req[0] = make_req(1'b1, 1'b1, 5, 6, 5);
    cur_req[1] = make_req(1'b1, 1'b1, 5, 9, 5);
    cur_req[2] = make_req(1'b1, 1'b1, 5, 5, 5);
    run_cycle();
    check_value("rsp[1].rs1_phys", 32'(rsp[1].rs1_phys), base);
    check_value("rsp[1].old_rd_phys", 32'(rsp[1].old_rd_phys), base);
    check_value("rsp[2].rs1_phys", 32'(rsp[2].rs1_phys), base + 1);
    check_value("rsp[2].rs2_phys", 32'(rsp[2].rs2_phys), base + 1);
    check_value("rsp[2].old_rd_phys", 32'(rsp[2].old_rd_phys), base + 1);
    // x0 destination and a clear rd_we forward nothing
    cur_req[0] = make_req(1'b1, 1'b1, 0, 0, 0);
    cur_req[1] = make_req(1'b1, 1'b0, 0, 0, 7);
    cur_req[2] = make_req(1'b1, 1'b1, 0, 7, 8);
    run_cycle();
    check_value("rsp[2].rs1_phys", 32'(rsp[2].rs1_phys), 0);
    check_value("rsp[2].rs2_phys", 32'(rsp[2].rs2_phys), 7);
    check_table();
endtask

task automatic commit_release();
    int tag_b;
    retire_all();
    cur_req[0] = make_req(1'b1, 1'b1, 0, 0, 10);
    run_cycle();
    retire_oldest(1);
    expect_mapping(10, 10);
    // Two renames of x11 leave the first commit stale
    cur_req[0] = make_req(1'b1, 1'b1, 0, 0, 11);
    run_cycle();
    tag_b = ref_ptr;
    cur_req[0] = make_req(1'b1, 1'b1, 0, 0, 11);
    run_cycle();
    retire_oldest(1);
    expect_mapping(11, 32 + tag_b);
    retire_oldest(1);
    expect_mapping(11, 11);
endtask

task automatic tag_exhaustion();
    retire_all();
    for (int g = 0; g < 10; g++) begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            cur_req[k] = make_req(1'b1, 1'b1, k, k + 1, 3 * g + k + 1);
        end
        run_cycle();
    end
    // Two tags left for three needing slots
    for (int k = 0; k < `RN_WIDTH; k++) begin
        cur_req[k] = make_req(1'b1, 1'b1, 1, 2, k + 20);
    end
    run_cycle();
    check_value("rename_ready_o", 32'(rename_ready), 3);
    check_value("rsp[0].valid", 32'(rsp[0].valid), 1);
    check_value("rsp[1].valid", 32'(rsp[1].valid), 1);
    check_value("rsp[2].valid", 32'(rsp[2].valid), 0);
    for (int k = 0; k < `RN_WIDTH; k++) begin
        cur_req[k] = make_req(1'b1, 1'b1, 1, 2, k + 20);
    end
    run_cycle();
    check_value("rename_ready_o", 32'(rename_ready), 0);
    for (int k = 0; k < `RN_WIDTH; k++) begin
        check_value($sformatf("rsp[%0d].valid", k), 32'(rsp[k].valid), 0);
    end
    retire_oldest(1);
    // The single returned tag goes straight to one request
    cur_req[0] = make_req(1'b1, 1'b1, 1, 2, 23);
    run_cycle();
    check_value("rename_ready_o", 32'(rename_ready), 1);
    check_value("rsp[0].valid", 32'(rsp[0].valid), 1);
    // Three commits into an empty pool
    retire_oldest(3);
    run_cycle();
    check_value("rename_ready_o", 32'(rename_ready), 7);
endtask

task automatic flush_restore();
    retire_all();
    for (int g = 0; g < 4; g++) begin
        random_group();
    end
    cur_flush = 1'b1;
    run_cycle();
    check_table();
endtask

// File: verification/rename_tb.sv
`timescale 1ns/1ns

`include "rename_params.svh"

module rename_tb;

    localparam int CLK_PERIOD = 100;
    // Rough length of the directed sequence in cycles
    localparam int TEST_CYCLES = 150;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

    // DUT ports
    logic clk;
    logic reset;
    logic flush_i;
    rename_pkg::rename_req_t [`RN_WIDTH-1:0] req;
    rename_pkg::commit_t [`RN_WIDTH-1:0] commit;
    rename_pkg::rename_rsp_t [`RN_WIDTH-1:0] rsp;
    logic [`RN_WIDTH-1:0] rename_ready;

    // Stimulus staged for the next falling edge
    rename_pkg::rename_req_t [`RN_WIDTH-1:0] cur_req;
    rename_pkg::commit_t [`RN_WIDTH-1:0] cur_commit;
    logic cur_flush;

    // Reference model: alias table, tag pointer, free count, tags in flight
    int ref_map [`RN_ARCH_REGS];
    int ref_ptr;
    int ref_free;
    rename_pkg::commit_t inflight [$];

    int error_count;
    int check_count;
    integer seed;

    rename_stage dut (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .req_i          (req),
        .commit_i       (commit),
        .rsp_o          (rsp),
        .rename_ready_o (rename_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Compare one observed value with the expected one
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    `include "rename_tests.svh"

    // ======================================================================
    // Watchdog
    // ======================================================================

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

    // ======================================================================
    // Reset and test sequence
    // ======================================================================

    initial begin
        seed = 2;
        clk = 1'b0;
        reset = 1'b0;
        flush_i = 1'b0;
        req = '0;
        commit = '0;
        cur_req = '0;
        cur_commit = '0;
        cur_flush = 1'b0;
        error_count = 0;
        check_count = 0;
        reset_model();
        // Ten cycles in reset, released on a falling edge
        repeat (10) @(negedge clk);
        reset = 1'b1;

        after_reset_state();
        tag_sequence();
        group_bypass();
        commit_release();
        tag_exhaustion();
        flush_restore();

        $display("Closing: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: verilog/rename_stage.sv
`timescale 1ns/1ns

`include "rename_params.svh"

module rename_stage (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        flush_i,
    input  rename_pkg::rename_req_t [`RN_WIDTH-1:0]     req_i,
    input  rename_pkg::commit_t [`RN_WIDTH-1:0]         commit_i,
    output rename_pkg::rename_rsp_t [`RN_WIDTH-1:0]     rsp_o,
    output logic [`RN_WIDTH-1:0]                        rename_ready_o
);

    // Allocator handshake with the lookup
    logic [`RN_WIDTH-1:0] need;
    logic [`RN_WIDTH-1:0] grant;
    rename_pkg::rob_tag_t [`RN_WIDTH-1:0] tag;

    // Lookup and table traffic
    rename_pkg::map_write_t [`RN_WIDTH-1:0] map_write;
    rename_pkg::rat_image_t map_image;

    // ======================================================================
    // ROB tag allocation
    // ======================================================================

    rob_tag_allocator u_alloc (
        .clk      (clk),
        .reset    (reset),
        .need_i   (need),
        .commit_i (commit_i),
        .grant_o  (grant),
        .tag_o    (tag),
        .ready_o  (rename_ready_o)
    );

    // ======================================================================
    // Lookup with intra-group bypass
    // ======================================================================

    rename_lookup u_lookup (
        .req_i   (req_i),
        .map_i   (map_image),
        .grant_i (grant),
        .tag_i   (tag),
        .need_o  (need),
        .rsp_o   (rsp_o),
        .write_o (map_write)
    );

    // ======================================================================
    // Alias table
    // ======================================================================

    rename_map u_map (
        .clk      (clk),
        .reset    (reset),
        .flush_i  (flush_i),
        .write_i  (map_write),
        .commit_i (commit_i),
        .map_o    (map_image)
    );

endmodule

// File: verilog/rename_map.sv
`timescale 1ns/1ns

`include "rename_params.svh"

module rename_map (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        flush_i,
    input  rename_pkg::map_write_t [`RN_WIDTH-1:0]      write_i,
    input  rename_pkg::commit_t [`RN_WIDTH-1:0]         commit_i,
    output rename_pkg::rat_image_t                      map_o
);

    // Current and next alias table
    rename_pkg::rat_image_t table_q;
    rename_pkg::rat_image_t table_d;

    // Every register mapped to its own file entry
    function automatic rename_pkg::rat_image_t identity_map();
        rename_pkg::rat_image_t img;
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            img[i] = rename_pkg::phys_addr_t'(i);
        end
        return img;
    endfunction

    // ======================================================================
    // Next state: commits, then renames, flush on top
    // ======================================================================

    always_comb begin
        table_d = table_q;

        // Release only if the entry still names the retiring tag
        for (int k = 0; k < `RN_WIDTH; k++) begin
            if (commit_i[k].valid && commit_i[k].arch != '0) begin
                if (table_d[commit_i[k].arch] == {1'b1, commit_i[k].rob_tag}) begin
                    table_d[commit_i[k].arch] = {1'b0, commit_i[k].arch};
                end
            end
        end

        // Slot order, so the youngest write to a register wins
        for (int k = 0; k < `RN_WIDTH; k++) begin
            // x0 stays hardwired to entry 0
            if (write_i[k].en && write_i[k].arch != '0) begin
                table_d[write_i[k].arch] = write_i[k].phys;
            end
        end

        // Flush discards everything in flight
        if (flush_i) begin
            table_d = identity_map();
        end
    end

    // ======================================================================
    // Table storage
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            table_q <= identity_map();
        end else begin
            table_q <= table_d;
        end
    end

    // Lookup sees the registered table only
    assign map_o = table_q;

endmodule

// File: verilog/rename_lookup.sv
`timescale 1ns/1ns

`include "rename_params.svh"

module rename_lookup (
    input  rename_pkg::rename_req_t [`RN_WIDTH-1:0]     req_i,
    input  rename_pkg::rat_image_t                      map_i,
    input  logic [`RN_WIDTH-1:0]                        grant_i,
    input  rename_pkg::rob_tag_t [`RN_WIDTH-1:0]        tag_i,
    output logic [`RN_WIDTH-1:0]                        need_o,
    output rename_pkg::rename_rsp_t [`RN_WIDTH-1:0]     rsp_o,
    output rename_pkg::map_write_t [`RN_WIDTH-1:0]      write_o
);

    // ======================================================================
    // Tag requests and table writes
    // ======================================================================

    always_comb begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            // Every valid instruction takes a ROB entry
            need_o[k] = req_i[k].valid;

            // Only a real destination updates the table
            write_o[k].en = grant_i[k] && req_i[k].rd_we && (req_i[k].rd != '0);
            write_o[k].arch = req_i[k].rd;
            // Physical 32 plus tag
            write_o[k].phys = {1'b1, tag_i[k]};
        end
    end

    // ======================================================================
    // Source and old destination with in-group bypass
    // ======================================================================

    always_comb begin
        rename_pkg::phys_addr_t rs1_map;
        rename_pkg::phys_addr_t rs2_map;
        rename_pkg::phys_addr_t rd_map;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            rs1_map = map_i[req_i[k].rs1];
            rs2_map = map_i[req_i[k].rs2];
            rd_map = map_i[req_i[k].rd];

            // Older slots in order, the youngest match is applied last
            for (int j = 0; j < k; j++) begin
                if (write_o[j].en && write_o[j].arch == req_i[k].rs1) begin
                    rs1_map = write_o[j].phys;
                end
                if (write_o[j].en && write_o[j].arch == req_i[k].rs2) begin
                    rs2_map = write_o[j].phys;
                end
                if (write_o[j].en && write_o[j].arch == req_i[k].rd) begin
                    rd_map = write_o[j].phys;
                end
            end

            rsp_o[k].valid = grant_i[k];
            rsp_o[k].rs1_phys = rs1_map;
            rsp_o[k].rs2_phys = rs2_map;
            // Destination fields are zero for an ungranted slot
            rsp_o[k].rd_phys = grant_i[k] ? {1'b1, tag_i[k]} : '0;
            rsp_o[k].old_rd_phys = grant_i[k] ? rd_map : '0;
        end
    end

endmodule

// File: verilog/rob_tag_allocator.sv
`timescale 1ns/1ns

`include "rename_params.svh"

module rob_tag_allocator (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic [`RN_WIDTH-1:0]                        need_i,
    input  rename_pkg::commit_t [`RN_WIDTH-1:0]         commit_i,
    output logic [`RN_WIDTH-1:0]                        grant_o,
    output rename_pkg::rob_tag_t [`RN_WIDTH-1:0]        tag_o,
    output logic [`RN_WIDTH-1:0]                        ready_o
);

    localparam int CNT_W = `RN_CNT_W;
    localparam int ROB_W = `RN_ROB_W;

    // Oldest free tag and number of free tags
    rename_pkg::rob_tag_t rd_ptr_q;
    logic [CNT_W-1:0] free_cnt_q;

    // Per-cycle totals
    logic [CNT_W-1:0] grant_cnt;
    logic [CNT_W-1:0] commit_cnt;

    // ======================================================================
    // Grant in slot order within the free count
    // ======================================================================

    always_comb begin
        logic [CNT_W-1:0] needed;
        needed = '0;
        grant_cnt = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            // Needing slots up to and including this one
            needed = needed + CNT_W'(need_i[k]);
            grant_o[k] = need_i[k] && (needed <= free_cnt_q);
            // Next tag after the grants of older slots
            tag_o[k] = rd_ptr_q + grant_cnt[ROB_W-1:0];
            grant_cnt = grant_cnt + CNT_W'(grant_o[k]);
        end
    end

    // Retiring tags come back in order, so only count them
    always_comb begin
        commit_cnt = '0;
        for (int k = 0; k < `RN_WIDTH; k++) begin
            commit_cnt = commit_cnt + CNT_W'(commit_i[k].valid);
        end
    end

    // Thermometer: slot k ready when more than k tags are free
    always_comb begin
        for (int k = 0; k < `RN_WIDTH; k++) begin
            ready_o[k] = free_cnt_q > CNT_W'(k);
        end
    end

    // ======================================================================
    // Pointer and count
    // ======================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rd_ptr_q <= '0;
            free_cnt_q <= CNT_W'(`RN_ROB_DEPTH);
        end else begin
            // Pointer wraps naturally at the tag width
            rd_ptr_q <= rd_ptr_q + grant_cnt[ROB_W-1:0];
            free_cnt_q <= free_cnt_q + commit_cnt - grant_cnt;
        end
    end

endmodule

// File: verilog/rename_pkg.sv
`include "rename_params.svh"

package rename_pkg;

    // Register numbers and reorder-buffer tags
    typedef logic [`RN_ARCH_W-1:0] arch_addr_t;

    // Top bit set means the value lives in a reorder-buffer entry
    typedef logic [`RN_PHYS_W-1:0] phys_addr_t;
    typedef logic [`RN_ROB_W-1:0] rob_tag_t;

    // ======================================================================
    // Per-slot bundles
    // ======================================================================

    // Decoded instruction entering rename
    typedef struct packed {
        logic       valid;
        logic       rd_we;
        arch_addr_t rs1;
        arch_addr_t rs2;
        arch_addr_t rd;
    } rename_req_t;

    // Renamed operands handed to dispatch
    typedef struct packed {
        logic       valid;
        phys_addr_t rs1_phys;
        phys_addr_t rs2_phys;
        phys_addr_t rd_phys;
        phys_addr_t old_rd_phys;
    } rename_rsp_t;

    // Retiring instruction from the reorder buffer
    typedef struct packed {
        logic       valid;
        arch_addr_t arch;
        rob_tag_t   rob_tag;
    } commit_t;

    // One alias table write produced by a renamed slot
    typedef struct packed {
        logic       en;
        arch_addr_t arch;
        phys_addr_t phys;
    } map_write_t;

    // Whole alias table, indexed by architectural register
    typedef phys_addr_t [`RN_ARCH_REGS-1:0] rat_image_t;

endpackage

// File: verilog/rename_params.svh
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// ======================================================================
// Register file and reorder buffer sizing
// ======================================================================

// Architectural and physical register counts
`define RN_ARCH_REGS 32
`define RN_PHYS_REGS 64

// Reorder-buffer tags, also the upper half of the physical space
`define RN_ROB_DEPTH 32

// Slots renamed per cycle
`define RN_WIDTH 3

// Address and counter widths
`define RN_ARCH_W 5
`define RN_PHYS_W 6
`define RN_ROB_W 5
`define RN_CNT_W 6

`endif
